// File: Makefile
# Verilator flow for the AXI LR/SC adapter

VERILATOR ?= verilator
FILELIST  ?= axi_lrsc_adapter.f
TB_TOP    ?= tb_axi_lrsc_adapter
RTL_TOP   ?= axi_lrsc_adapter
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: axi_lrsc_adapter.f
+incdir+common
common/lrsc_pkg.sv
lrsc/lrsc_res_table.sv
lrsc/lrsc_read_ctrl.sv
lrsc/lrsc_write_ctrl.sv
hdl/axi_lrsc_adapter.sv
bench/axi_lrsc_checker.sv
bench/tb_axi_lrsc_adapter.sv

// File: bench/axi_lrsc_checker.sv
/*
 * AXI LR/SC adapter protocol checker
 * Bound to the adapter, watches reset behavior, valid stability and response codes
 */

`timescale 1ns/1ps

module axi_lrsc_checker (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            slv_ar_valid_i,
    input logic            slv_ar_ready_o,
    input lrsc_pkg::len_t  slv_ar_len_i,
    input logic            slv_ar_lock_i,
    input logic            slv_r_valid_o,
    input logic            slv_r_ready_i,
    input lrsc_pkg::resp_t slv_r_resp_o,
    input logic            slv_aw_valid_i,
    input logic            slv_aw_ready_o,
    input lrsc_pkg::len_t  slv_aw_len_i,
    input logic            slv_aw_lock_i,
    input logic            slv_b_valid_o,
    input logic            slv_b_ready_i,
    input lrsc_pkg::resp_t slv_b_resp_o,
    input logic            mst_ar_valid_o,
    input logic            mst_aw_valid_o,
    input logic            mst_w_valid_o
);

    import lrsc_pkg::*;

    int unsigned error_count = 0;
    logic        rd_burst_lock_q;
    logic        wr_burst_lock_q;
    logic        aw_open_q;

    // Locked bursts seen on the address channels, and an open write transaction
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_burst_lock_q <= 1'b0;
            wr_burst_lock_q <= 1'b0;
            aw_open_q       <= 1'b0;
        end else begin
            if (slv_ar_valid_i && slv_ar_ready_o) begin
                rd_burst_lock_q <= slv_ar_lock_i && (slv_ar_len_i != '0);
            end
            if (slv_aw_valid_i && slv_aw_ready_o) begin
                wr_burst_lock_q <= slv_aw_lock_i && (slv_aw_len_i != '0);
                aw_open_q       <= 1'b1;
            end else if (slv_b_valid_o && slv_b_ready_i) begin
                aw_open_q <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk_i) $rose(rst_ni) |->
        !(mst_ar_valid_o || mst_aw_valid_o || mst_w_valid_o))
    else begin
        error_count++;
        $error("Master side valid high in the first cycle after reset");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o)
    else begin
        error_count++;
        $error("R valid dropped before the beat was accepted");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_b_valid_o && !slv_b_ready_i |=> slv_b_valid_o)
    else begin
        error_count++;
        $error("B valid dropped before the response was accepted");
    end

    // Locked bursts are plain accesses
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_r_valid_o && rd_burst_lock_q |-> slv_r_resp_o != EXOKAY)
    else begin
        error_count++;
        $error("EXOKAY returned for a locked read burst");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_b_valid_o && wr_burst_lock_q |-> slv_b_resp_o != EXOKAY)
    else begin
        error_count++;
        $error("EXOKAY returned for a locked write burst");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_b_valid_o |-> aw_open_q)
    else begin
        error_count++;
        $error("B valid raised without an accepted AW");
    end

endmodule

bind axi_lrsc_adapter axi_lrsc_checker i_checker (.*);

// File: bench/tb_axi_lrsc_adapter.sv
/*
 * Testbench for the AXI LR/SC adapter
 * Drives the upstream port and models a 16-word memory on the downstream port
 */

`timescale 1ns/1ps

`include "lrsc_defines.svh"

module tb_axi_lrsc_adapter;

    import lrsc_pkg::*;

    localparam int TIMEOUT = 100;

    logic  clk_i;
    logic  rst_ni;
    // Upstream side
    logic  slv_ar_valid_i, slv_ar_ready_o, slv_ar_lock_i;
    addr_t slv_ar_addr_i;
    id_t   slv_ar_id_i;
    len_t  slv_ar_len_i;
    logic  slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
    data_t slv_r_data_o;
    resp_t slv_r_resp_o;
    id_t   slv_r_id_o;
    logic  slv_aw_valid_i, slv_aw_ready_o, slv_aw_lock_i;
    addr_t slv_aw_addr_i;
    id_t   slv_aw_id_i;
    len_t  slv_aw_len_i;
    logic  slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
    data_t slv_w_data_i;
    logic [`LRSC_STRB_W-1:0] slv_w_strb_i;
    logic  slv_b_valid_o, slv_b_ready_i;
    resp_t slv_b_resp_o;
    id_t   slv_b_id_o;
    // Memory side
    logic  mst_ar_valid_o, mst_ar_ready_i;
    addr_t mst_ar_addr_o;
    id_t   mst_ar_id_o;
    len_t  mst_ar_len_o;
    logic  mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
    data_t mst_r_data_i;
    resp_t mst_r_resp_i;
    id_t   mst_r_id_i;
    logic  mst_aw_valid_o, mst_aw_ready_i;
    addr_t mst_aw_addr_o;
    id_t   mst_aw_id_o;
    len_t  mst_aw_len_o;
    logic  mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
    data_t mst_w_data_o;
    logic [`LRSC_STRB_W-1:0] mst_w_strb_o;
    logic  mst_b_valid_i, mst_b_ready_o;
    resp_t mst_b_resp_i;
    id_t   mst_b_id_i;

    // Memory model state and the expected memory contents
    data_t       mem [16];
    data_t       exp_mem [16];
    addr_t       rd_addr, wr_addr;
    id_t         rd_id, wr_id;
    int unsigned rd_left;
    logic        b_pend;
    logic        ar_fire, r_fire, aw_fire, w_fire, b_fire;

    // Upstream responses captured at the accepting edge
    data_t r_data_s;
    resp_t r_resp_s, b_resp_s;
    logic  r_last_s;
    id_t   r_id_s, b_id_s;

    integer seed;
    id_t    id_a, id_b;

    axi_lrsc_adapter i_axi_lrsc_adapter (.*);

    always #5 clk_i = ~clk_i;

    // Memory samples handshakes mid-cycle and updates 1 ns after the edge
    always begin
        @(negedge clk_i);
        ar_fire = mst_ar_valid_o && mst_ar_ready_i;
        r_fire  = mst_r_valid_i && mst_r_ready_o;
        aw_fire = mst_aw_valid_o && mst_aw_ready_i;
        w_fire  = mst_w_valid_o && mst_w_ready_i;
        b_fire  = mst_b_valid_i && mst_b_ready_o;
        if (ar_fire) begin
            rd_addr = mst_ar_addr_o;
            rd_id   = mst_ar_id_o;
            rd_left = int'(mst_ar_len_o) + 1;
        end
        if (r_fire) begin
            rd_left = rd_left - 1;
            rd_addr = rd_addr + 4;
        end
        if (aw_fire) begin
            // Burst length reaches the memory unchanged
            check_equal("AW len", 32'(mst_aw_len_o), 32'(slv_aw_len_i));
            wr_addr = mst_aw_addr_o;
            wr_id   = mst_aw_id_o;
        end
        if (w_fire) begin
            for (int k = 0; k < `LRSC_STRB_W; k++) begin
                if (mst_w_strb_o[k]) begin
                    mem[wr_addr[5:2]][8*k +: 8] = mst_w_data_o[8*k +: 8];
                end
            end
            wr_addr = wr_addr + 4;
            if (mst_w_last_o) begin
                b_pend = 1'b1;
            end
        end
        if (b_fire) begin
            b_pend = 1'b0;
        end
        @(posedge clk_i);
        #1;
        mst_r_valid_i = (rd_left != 0);
        mst_r_data_i  = mem[rd_addr[5:2]];
        mst_r_last_i  = (rd_left == 1);
        mst_r_id_i    = rd_id;
        mst_b_valid_i = b_pend;
        mst_b_id_i    = wr_id;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    function automatic logic channel_fire(input string ch);
        case (ch)
            "AR":    return slv_ar_valid_i && slv_ar_ready_o;
            "R":     return slv_r_valid_o && slv_r_ready_i;
            "AW":    return slv_aw_valid_i && slv_aw_ready_o;
            "W":     return slv_w_valid_i && slv_w_ready_o;
            default: return slv_b_valid_o && slv_b_ready_i;
        endcase
    endfunction

    // Returns 1 ns after the edge that completed the handshake
    task automatic wait_fire(input string ch);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!channel_fire(ch)) begin
            if (cycles == TIMEOUT) begin
                stop_run($sformatf("Timeout: no %s handshake within %0d cycles", ch, TIMEOUT));
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        r_data_s = slv_r_data_o;
        r_resp_s = slv_r_resp_o;
        r_last_s = slv_r_last_o;
        r_id_s   = slv_r_id_o;
        b_resp_s = slv_b_resp_o;
        b_id_s   = slv_b_id_o;
        @(posedge clk_i);
        #1;
    endtask

    // Hold ready low for one or two cycles to exercise back-pressure
    task automatic stall;
        repeat (1 + ($unsigned($random(seed)) % 2)) @(posedge clk_i);
        #1;
    endtask

    task automatic do_read(input id_t id, input addr_t addr, input len_t len,
                           input logic lock, input resp_t exp_resp);
        int       beats;
        logic [3:0] idx;
        beats          = int'(len) + 1;
        slv_ar_valid_i = 1'b1;
        slv_ar_addr_i  = addr;
        slv_ar_id_i    = id;
        slv_ar_len_i   = len;
        slv_ar_lock_i  = lock;
        wait_fire("AR");
        slv_ar_valid_i = 1'b0;
        stall();
        slv_r_ready_i = 1'b1;
        for (int i = 0; i < beats; i++) begin
            wait_fire("R");
            idx = 4'((addr >> 2) + addr_t'(i));
            check_equal("R data", r_data_s, exp_mem[idx]);
            check_equal("R resp", 32'(r_resp_s), 32'(exp_resp));
            check_equal("R id", 32'(r_id_s), 32'(id));
            check_equal("R last", 32'(r_last_s), 32'(i == beats - 1));
        end
        slv_r_ready_i = 1'b0;
    endtask

    task automatic do_write(input id_t id, input addr_t addr, input len_t len,
                            input logic lock, input resp_t exp_resp, input logic stored);
        int       beats;
        logic [3:0] idx;
        beats          = int'(len) + 1;
        slv_aw_valid_i = 1'b1;
        slv_aw_addr_i  = addr;
        slv_aw_id_i    = id;
        slv_aw_len_i   = len;
        slv_aw_lock_i  = lock;
        wait_fire("AW");
        slv_aw_valid_i = 1'b0;
        for (int i = 0; i < beats; i++) begin
            slv_w_valid_i = 1'b1;
            slv_w_data_i  = data_t'($random(seed));
            slv_w_strb_i  = '1;
            slv_w_last_i  = (i == beats - 1);
            wait_fire("W");
            idx = 4'((addr >> 2) + addr_t'(i));
            if (stored) begin
                exp_mem[idx] = slv_w_data_i;
            end
        end
        slv_w_valid_i = 1'b0;
        slv_w_last_i  = 1'b0;
        stall();
        slv_b_ready_i = 1'b1;
        wait_fire("B");
        slv_b_ready_i = 1'b0;
        check_equal("B resp", 32'(b_resp_s), 32'(exp_resp));
        check_equal("B id", 32'(b_id_s), 32'(id));
    endtask

    task automatic init_inputs;
        slv_ar_valid_i = 1'b0;
        slv_ar_addr_i  = '0;
        slv_ar_id_i    = '0;
        slv_ar_len_i   = '0;
        slv_ar_lock_i  = 1'b0;
        slv_r_ready_i  = 1'b0;
        slv_aw_valid_i = 1'b0;
        slv_aw_addr_i  = '0;
        slv_aw_id_i    = '0;
        slv_aw_len_i   = '0;
        slv_aw_lock_i  = 1'b0;
        slv_w_valid_i  = 1'b0;
        slv_w_data_i   = '0;
        slv_w_strb_i   = '0;
        slv_w_last_i   = 1'b0;
        slv_b_ready_i  = 1'b0;
        // The memory always accepts addresses and data
        mst_ar_ready_i = 1'b1;
        mst_aw_ready_i = 1'b1;
        mst_w_ready_i  = 1'b1;
        mst_r_valid_i  = 1'b0;
        mst_r_data_i   = '0;
        mst_r_resp_i   = OKAY;
        mst_r_last_i   = 1'b0;
        mst_r_id_i     = '0;
        mst_b_valid_i  = 1'b0;
        mst_b_resp_i   = OKAY;
        mst_b_id_i     = '0;
        rd_left        = 0;
        b_pend         = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i]     = data_t'(i * 4) ^ 32'hA5A5_A5A5;
            exp_mem[i] = data_t'(i * 4) ^ 32'hA5A5_A5A5;
        end
    endtask

    // Bound checker failures end the run too
    always @(negedge clk_i) begin
        if (i_axi_lrsc_adapter.i_checker.error_count != 0) begin
            stop_run("A protocol assertion in the bound checker failed");
        end
    end

    initial begin
        seed   = 60325;
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        init_inputs();
        // The window needs an end above its begin
        assert (`LRSC_EXCL_END > `LRSC_EXCL_BEGIN) else begin
            stop_run("The exclusive window end does not lie above its begin");
        end
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        id_a = id_t'($random(seed));
        id_b = id_a ^ id_t'(1);

        // Plain write and read back inside the window
        do_write(id_a, 32'h1010, 8'd0, 1'b0, OKAY, 1'b1);
        do_read(id_a, 32'h1010, 8'd0, 1'b0, OKAY);

        // Exclusive read inside and outside the window
        do_read(id_b, 32'h1020, 8'd0, 1'b1, EXOKAY);
        do_read(id_b, 32'h3020, 8'd0, 1'b1, OKAY);

        // Successful LR/SC pair
        do_read(id_a, 32'h1024, 8'd0, 1'b1, EXOKAY);
        do_write(id_a, 32'h1024, 8'd0, 1'b1, EXOKAY, 1'b1);
        do_read(id_a, 32'h1024, 8'd0, 1'b0, OKAY);

        // SC without a reservation is answered locally
        do_write(id_b, 32'h1028, 8'd0, 1'b1, OKAY, 1'b0);
        do_read(id_b, 32'h1028, 8'd0, 1'b0, OKAY);

        // Reservation lost to a plain write from another ID
        do_read(id_a, 32'h1030, 8'd0, 1'b1, EXOKAY);
        do_write(id_b, 32'h1030, 8'd0, 1'b0, OKAY, 1'b1);
        do_write(id_a, 32'h1030, 8'd0, 1'b1, OKAY, 1'b0);
        do_read(id_a, 32'h1030, 8'd0, 1'b0, OKAY);

        // Locked bursts act as plain accesses
        do_read(id_b, 32'h1000, 8'd3, 1'b1, OKAY);
        do_write(id_b, 32'h1000, 8'd3, 1'b1, OKAY, 1'b1);
        do_read(id_a, 32'h1000, 8'd3, 1'b0, OKAY);

        @(posedge clk_i);
        if (i_axi_lrsc_adapter.i_checker.error_count != 0) begin
            stop_run("The bound checker reported assertion failures");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: common/lrsc_defines.svh
/*
 * LR/SC adapter configuration macros
 * Bus widths and the closed address window that supports exclusive access
 */

`ifndef LRSC_DEFINES_SVH
`define LRSC_DEFINES_SVH

// AXI widths
`define LRSC_ADDR_W 32
`define LRSC_DATA_W 32
`define LRSC_ID_W   4

// Exclusive window, both bounds inclusive
// LRSC_EXCL_END must be strictly greater than LRSC_EXCL_BEGIN
`define LRSC_EXCL_BEGIN 32'h0000_1000
`define LRSC_EXCL_END   32'h0000_1FFF

// Strobe width follows the data width
`define LRSC_STRB_W (`LRSC_DATA_W / 8)

`endif

// File: common/lrsc_pkg.sv
/*
 * LR/SC adapter package
 * Bus field types, AXI response codes and the channel controller states
 */

`include "lrsc_defines.svh"

package lrsc_pkg;

    typedef logic [`LRSC_ADDR_W-1:0] addr_t;
    typedef logic [`LRSC_ID_W-1:0]   id_t;
    typedef logic [`LRSC_DATA_W-1:0] data_t;
    typedef logic [7:0]              len_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    typedef enum logic [1:0] {R_IDLE, R_WAIT_AR, R_WAIT_R} r_state_t;

    typedef enum logic [2:0] {
        AW_IDLE, W_FORWARD, W_BYPASS, W_DROP, B_FORWARD, B_INJECT
    } w_state_t;

    // True when the address lies in the exclusive window
    function automatic logic in_excl_window(addr_t addr);
        return (addr >= addr_t'(`LRSC_EXCL_BEGIN)) && (addr <= addr_t'(`LRSC_EXCL_END));
    endfunction

endpackage

// File: hdl/axi_lrsc_adapter.sv
/*
 * AXI4 LR/SC adapter top level
 * Adds exclusive access in one address window in front of a plain memory slave
 */

`timescale 1ns/1ps

`include "lrsc_defines.svh"

module axi_lrsc_adapter (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Upstream master
    input  logic                    slv_ar_valid_i,
    output logic                    slv_ar_ready_o,
    input  lrsc_pkg::addr_t         slv_ar_addr_i,
    input  lrsc_pkg::id_t           slv_ar_id_i,
    input  lrsc_pkg::len_t          slv_ar_len_i,
    input  logic                    slv_ar_lock_i,
    output logic                    slv_r_valid_o,
    input  logic                    slv_r_ready_i,
    output lrsc_pkg::data_t         slv_r_data_o,
    output lrsc_pkg::resp_t         slv_r_resp_o,
    output logic                    slv_r_last_o,
    output lrsc_pkg::id_t           slv_r_id_o,
    input  logic                    slv_aw_valid_i,
    output logic                    slv_aw_ready_o,
    input  lrsc_pkg::addr_t         slv_aw_addr_i,
    input  lrsc_pkg::id_t           slv_aw_id_i,
    input  lrsc_pkg::len_t          slv_aw_len_i,
    input  logic                    slv_aw_lock_i,
    input  logic                    slv_w_valid_i,
    output logic                    slv_w_ready_o,
    input  lrsc_pkg::data_t         slv_w_data_i,
    input  logic [`LRSC_STRB_W-1:0] slv_w_strb_i,
    input  logic                    slv_w_last_i,
    output logic                    slv_b_valid_o,
    input  logic                    slv_b_ready_i,
    output lrsc_pkg::resp_t         slv_b_resp_o,
    output lrsc_pkg::id_t           slv_b_id_o,
    // Downstream memory, no lock signals
    output logic                    mst_ar_valid_o,
    input  logic                    mst_ar_ready_i,
    output lrsc_pkg::addr_t         mst_ar_addr_o,
    output lrsc_pkg::id_t           mst_ar_id_o,
    output lrsc_pkg::len_t          mst_ar_len_o,
    input  logic                    mst_r_valid_i,
    output logic                    mst_r_ready_o,
    input  lrsc_pkg::data_t         mst_r_data_i,
    input  lrsc_pkg::resp_t         mst_r_resp_i,
    input  logic                    mst_r_last_i,
    input  lrsc_pkg::id_t           mst_r_id_i,
    output logic                    mst_aw_valid_o,
    input  logic                    mst_aw_ready_i,
    output lrsc_pkg::addr_t         mst_aw_addr_o,
    output lrsc_pkg::id_t           mst_aw_id_o,
    output lrsc_pkg::len_t          mst_aw_len_o,
    output logic                    mst_w_valid_o,
    input  logic                    mst_w_ready_i,
    output lrsc_pkg::data_t         mst_w_data_o,
    output logic [`LRSC_STRB_W-1:0] mst_w_strb_o,
    output logic                    mst_w_last_o,
    input  logic                    mst_b_valid_i,
    output logic                    mst_b_ready_o,
    input  lrsc_pkg::resp_t         mst_b_resp_i,
    input  lrsc_pkg::id_t           mst_b_id_i
);

    import lrsc_pkg::*;

    logic  set_en;
    addr_t set_addr;
    id_t   set_id;
    addr_t check_addr;
    id_t   check_id;
    logic  check_hit;
    logic  clr_en;
    addr_t clr_addr;

    // Payload fields need no adaptation
    assign mst_ar_addr_o = slv_ar_addr_i;
    assign mst_ar_id_o   = slv_ar_id_i;
    assign mst_ar_len_o  = slv_ar_len_i;
    assign slv_r_data_o  = mst_r_data_i;
    assign slv_r_last_o  = mst_r_last_i;
    assign slv_r_id_o    = mst_r_id_i;
    assign mst_aw_addr_o = slv_aw_addr_i;
    assign mst_aw_id_o   = slv_aw_id_i;
    assign mst_aw_len_o  = slv_aw_len_i;
    assign mst_w_data_o  = slv_w_data_i;
    assign mst_w_strb_o  = slv_w_strb_i;
    assign mst_w_last_o  = slv_w_last_i;

    lrsc_read_ctrl i_read_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_ar_valid_i (slv_ar_valid_i),
        .slv_ar_ready_o (slv_ar_ready_o),
        .slv_ar_addr_i  (slv_ar_addr_i),
        .slv_ar_id_i    (slv_ar_id_i),
        .slv_ar_len_i   (slv_ar_len_i),
        .slv_ar_lock_i  (slv_ar_lock_i),
        .slv_r_valid_o  (slv_r_valid_o),
        .slv_r_ready_i  (slv_r_ready_i),
        .slv_r_resp_o   (slv_r_resp_o),
        .mst_ar_valid_o (mst_ar_valid_o),
        .mst_ar_ready_i (mst_ar_ready_i),
        .mst_r_valid_i  (mst_r_valid_i),
        .mst_r_ready_o  (mst_r_ready_o),
        .mst_r_resp_i   (mst_r_resp_i),
        .mst_r_last_i   (mst_r_last_i),
        .set_en_o       (set_en),
        .set_addr_o     (set_addr),
        .set_id_o       (set_id)
    );

    lrsc_write_ctrl i_write_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .slv_aw_addr_i  (slv_aw_addr_i),
        .slv_aw_id_i    (slv_aw_id_i),
        .slv_aw_len_i   (slv_aw_len_i),
        .slv_aw_lock_i  (slv_aw_lock_i),
        .slv_w_valid_i  (slv_w_valid_i),
        .slv_w_ready_o  (slv_w_ready_o),
        .slv_w_last_i   (slv_w_last_i),
        .slv_b_valid_o  (slv_b_valid_o),
        .slv_b_ready_i  (slv_b_ready_i),
        .slv_b_resp_o   (slv_b_resp_o),
        .slv_b_id_o     (slv_b_id_o),
        .mst_aw_valid_o (mst_aw_valid_o),
        .mst_aw_ready_i (mst_aw_ready_i),
        .mst_w_valid_o  (mst_w_valid_o),
        .mst_w_ready_i  (mst_w_ready_i),
        .mst_b_valid_i  (mst_b_valid_i),
        .mst_b_ready_o  (mst_b_ready_o),
        .mst_b_resp_i   (mst_b_resp_i),
        .mst_b_id_i     (mst_b_id_i),
        .check_addr_o   (check_addr),
        .check_id_o     (check_id),
        .check_hit_i    (check_hit),
        .clr_en_o       (clr_en),
        .clr_addr_o     (clr_addr)
    );

    lrsc_res_table i_res_table (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .set_en_i     (set_en),
        .set_addr_i   (set_addr),
        .set_id_i     (set_id),
        .check_addr_i (check_addr),
        .check_id_i   (check_id),
        .clr_en_i     (clr_en),
        .clr_addr_i   (clr_addr),
        .check_hit_o  (check_hit)
    );

endmodule

// File: lrsc/lrsc_read_ctrl.sv
/*
 * Read channel controller
 * Forwards AR, sets reservations for exclusive reads, rewrites R responses
 */

`timescale 1ns/1ps

module lrsc_read_ctrl (
    input  logic            clk_i,
    input  logic            rst_ni,
    // Upstream AR and R
    input  logic            slv_ar_valid_i,
    output logic            slv_ar_ready_o,
    input  lrsc_pkg::addr_t slv_ar_addr_i,
    input  lrsc_pkg::id_t   slv_ar_id_i,
    input  lrsc_pkg::len_t  slv_ar_len_i,
    input  logic            slv_ar_lock_i,
    output logic            slv_r_valid_o,
    input  logic            slv_r_ready_i,
    output lrsc_pkg::resp_t slv_r_resp_o,
    // Downstream AR and R
    output logic            mst_ar_valid_o,
    input  logic            mst_ar_ready_i,
    input  logic            mst_r_valid_i,
    output logic            mst_r_ready_o,
    input  lrsc_pkg::resp_t mst_r_resp_i,
    input  logic            mst_r_last_i,
    // Reservation set strobe
    output logic            set_en_o,
    output lrsc_pkg::addr_t set_addr_o,
    output lrsc_pkg::id_t   set_id_o
);

    import lrsc_pkg::*;

    r_state_t state_d, state_q;
    logic     excl_d, excl_q;
    logic     ar_excl;

    // Locked single-beat read inside the window
    assign ar_excl = slv_ar_lock_i && (slv_ar_len_i == len_t'(0)) && in_excl_window(slv_ar_addr_i);

    assign set_addr_o = slv_ar_addr_i;
    assign set_id_o   = slv_ar_id_i;

    always_comb begin
        state_d        = state_q;
        excl_d         = excl_q;
        slv_ar_ready_o = 1'b0;
        mst_ar_valid_o = 1'b0;
        slv_r_valid_o  = 1'b0;
        mst_r_ready_o  = 1'b0;
        slv_r_resp_o   = OKAY;
        set_en_o       = 1'b0;

        case (state_q)
            R_IDLE: begin
                if (slv_ar_valid_i) begin
                    set_en_o       = ar_excl;
                    excl_d         = ar_excl;
                    mst_ar_valid_o = 1'b1;
                    slv_ar_ready_o = mst_ar_ready_i;
                    state_d        = mst_ar_ready_i ? R_WAIT_R : R_WAIT_AR;
                end
            end

            R_WAIT_AR: begin
                mst_ar_valid_o = slv_ar_valid_i;
                slv_ar_ready_o = mst_ar_ready_i;
                if (slv_ar_valid_i && mst_ar_ready_i) begin
                    state_d = R_WAIT_R;
                end
            end

            R_WAIT_R: begin
                slv_r_valid_o = mst_r_valid_i;
                mst_r_ready_o = slv_r_ready_i;
                // Success codes follow the exclusive flag, errors pass as they are
                if (!mst_r_resp_i[1]) begin
                    slv_r_resp_o = excl_q ? EXOKAY : OKAY;
                end else begin
                    slv_r_resp_o = mst_r_resp_i;
                end
                if (mst_r_valid_i && slv_r_ready_i && mst_r_last_i) begin
                    excl_d  = 1'b0;
                    state_d = R_IDLE;
                end
            end

            default: begin
                state_d = R_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= R_IDLE;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            excl_q  <= excl_d;
        end
    end

endmodule

// File: lrsc/lrsc_res_table.sv
/*
 * Reservation table
 * One address reservation per transaction ID with set, clear and check
 */

`timescale 1ns/1ps

module lrsc_res_table (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            set_en_i,
    input  lrsc_pkg::addr_t set_addr_i,
    input  lrsc_pkg::id_t   set_id_i,
    input  lrsc_pkg::addr_t check_addr_i,
    input  lrsc_pkg::id_t   check_id_i,
    input  logic            clr_en_i,
    input  lrsc_pkg::addr_t clr_addr_i,
    output logic            check_hit_o
);

    import lrsc_pkg::*;

    localparam int unsigned NUM_ENTRIES = 2 ** $bits(id_t);

    logic [NUM_ENTRIES-1:0] valid_q;
    addr_t                  addr_q [NUM_ENTRIES];

    // A set on the same entry wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            for (int unsigned i = 0; i < NUM_ENTRIES; i++) begin
                if (set_en_i && (set_id_i == id_t'(i))) begin
                    valid_q[i] <= 1'b1;
                end else if (clr_en_i && (addr_q[i] == clr_addr_i)) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_en_i) begin
            addr_q[set_id_i] <= set_addr_i;
        end
    end

    // Check looks at the registered contents only
    assign check_hit_o = valid_q[check_id_i] && (addr_q[check_id_i] == check_addr_i);

endmodule

// File: lrsc/lrsc_write_ctrl.sv
/*
 * Write channel controller
 * Checks reservations for exclusive writes, forwards or drops the data,
 * clears reservations on forwarded writes and returns the B response
 */

`timescale 1ns/1ps

module lrsc_write_ctrl (
    input  logic            clk_i,
    input  logic            rst_ni,
    // Upstream AW, W and B
    input  logic            slv_aw_valid_i,
    output logic            slv_aw_ready_o,
    input  lrsc_pkg::addr_t slv_aw_addr_i,
    input  lrsc_pkg::id_t   slv_aw_id_i,
    input  lrsc_pkg::len_t  slv_aw_len_i,
    input  logic            slv_aw_lock_i,
    input  logic            slv_w_valid_i,
    output logic            slv_w_ready_o,
    input  logic            slv_w_last_i,
    output logic            slv_b_valid_o,
    input  logic            slv_b_ready_i,
    output lrsc_pkg::resp_t slv_b_resp_o,
    output lrsc_pkg::id_t   slv_b_id_o,
    // Downstream AW, W and B
    output logic            mst_aw_valid_o,
    input  logic            mst_aw_ready_i,
    output logic            mst_w_valid_o,
    input  logic            mst_w_ready_i,
    input  logic            mst_b_valid_i,
    output logic            mst_b_ready_o,
    input  lrsc_pkg::resp_t mst_b_resp_i,
    input  lrsc_pkg::id_t   mst_b_id_i,
    // Reservation check and clear
    output lrsc_pkg::addr_t check_addr_o,
    output lrsc_pkg::id_t   check_id_o,
    input  logic            check_hit_i,
    output logic            clr_en_o,
    output lrsc_pkg::addr_t clr_addr_o
);

    import lrsc_pkg::*;

    w_state_t state_d, state_q;
    logic     excl_d, excl_q;
    addr_t    addr_q;
    id_t      id_q;
    logic     aw_in_window;
    logic     aw_excl;

    assign aw_in_window = in_excl_window(slv_aw_addr_i);
    assign aw_excl      = slv_aw_lock_i && (slv_aw_len_i == len_t'(0));

    // The table is only consulted while idle, so the AW fields go straight in
    assign check_addr_o = slv_aw_addr_i;
    assign check_id_o   = slv_aw_id_i;
    assign clr_addr_o   = addr_q;

    always_comb begin
        state_d        = state_q;
        excl_d         = excl_q;
        slv_aw_ready_o = 1'b0;
        mst_aw_valid_o = 1'b0;
        slv_w_ready_o  = 1'b0;
        mst_w_valid_o  = 1'b0;
        slv_b_valid_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
        slv_b_resp_o   = OKAY;
        slv_b_id_o     = '0;
        clr_en_o       = 1'b0;

        case (state_q)
            AW_IDLE: begin
                if (slv_aw_valid_i) begin
                    if (!aw_in_window) begin
                        mst_aw_valid_o = 1'b1;
                        slv_aw_ready_o = mst_aw_ready_i;
                        if (mst_aw_ready_i) begin
                            state_d = W_BYPASS;
                        end
                    end else if (aw_excl && !check_hit_i) begin
                        // Failed store conditional, never seen downstream
                        slv_aw_ready_o = 1'b1;
                        state_d        = W_DROP;
                    end else begin
                        mst_aw_valid_o = 1'b1;
                        slv_aw_ready_o = mst_aw_ready_i;
                        if (mst_aw_ready_i) begin
                            excl_d  = aw_excl;
                            state_d = W_FORWARD;
                        end
                    end
                end
            end

            W_FORWARD: begin
                mst_w_valid_o = slv_w_valid_i;
                slv_w_ready_o = mst_w_ready_i;
                if (slv_w_valid_i && mst_w_ready_i && slv_w_last_i) begin
                    clr_en_o = 1'b1;
                    state_d  = B_FORWARD;
                end
            end

            W_BYPASS: begin
                mst_w_valid_o = slv_w_valid_i;
                slv_w_ready_o = mst_w_ready_i;
                if (slv_w_valid_i && mst_w_ready_i && slv_w_last_i) begin
                    state_d = B_FORWARD;
                end
            end

            W_DROP: begin
                slv_w_ready_o = 1'b1;
                if (slv_w_valid_i && slv_w_last_i) begin
                    state_d = B_INJECT;
                end
            end

            B_FORWARD: begin
                slv_b_valid_o = mst_b_valid_i;
                mst_b_ready_o = slv_b_ready_i;
                slv_b_id_o    = mst_b_id_i;
                if (!mst_b_resp_i[1]) begin
                    slv_b_resp_o = excl_q ? EXOKAY : OKAY;
                end else begin
                    slv_b_resp_o = mst_b_resp_i;
                end
                if (mst_b_valid_i && slv_b_ready_i) begin
                    excl_d  = 1'b0;
                    state_d = AW_IDLE;
                end
            end

            B_INJECT: begin
                slv_b_valid_o = 1'b1;
                slv_b_id_o    = id_q;
                if (slv_b_ready_i) begin
                    state_d = AW_IDLE;
                end
            end

            default: begin
                state_d = AW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= AW_IDLE;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            excl_q  <= excl_d;
        end
    end

    // AW fields kept for the clear and the injected response
    always_ff @(posedge clk_i) begin
        if (slv_aw_valid_i && slv_aw_ready_o) begin
            addr_q <= slv_aw_addr_i;
            id_q   <= slv_aw_id_i;
        end
    end

endmodule
